// ==== dv/fabric_tb.sv ====
// One request per call from a single initiator. Outputs are sampled on the falling edge and the key is fixed after reset.
`timescale 1ns/100ps
`default_nettype none

module fabric_tb;
    import fabric_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_REQS       = 74;
    localparam int MARGIN_CYCLES  = 50;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_REQS * 4 + MARGIN_CYCLES;

    logic                             clk_i;
    logic                             reset_i;
    bus_req_t                         req_i;
    bus_rsp_t                         rsp_o;
    logic [KEY_WORDS-1:0][DATA_W-1:0] obf_key_i;
    logic                             debug_locked_i;
    logic [NUM_INTR-1:0]              intr_o;
    logic [DATA_W-1:0]                generic_out_o;

    bus_rsp_t exp_rsp;      // Expected answer to the request on req_i
    bus_rsp_t exp_rsp_q;    // Expected answer one cycle later
    integer   seed = 45588;
    int       errors = 0;

    // Reference model
    logic [DATA_W-1:0]                iccm_model [ICCM_WORDS];
    logic [KEY_WORDS-1:0][DATA_W-1:0] key_model;
    logic                             lock_model;
    logic [NUM_CTRL_INTR-1:0]         status_model;
    logic [NUM_CTRL_INTR-1:0]         en_model;
    logic [DATA_W-1:0]                gen_model;
    logic                             cleared_model;

    secure_soc_fabric secure_soc_fabric_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_i          (req_i),
        .rsp_o          (rsp_o),
        .obf_key_i      (obf_key_i),
        .debug_locked_i (debug_locked_i),
        .intr_o         (intr_o),
        .generic_out_o  (generic_out_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        exp_rsp_q <= exp_rsp;
    end

    // ========================================================================
    // Response checks one cycle after each request
    // ========================================================================
    a_rsp_valid: assert property (@(negedge clk_i) disable iff (reset_i)
        req_i.valid |=> rsp_o.valid)
        else begin
            errors++;
            $display("MISMATCH at %0t: rsp_o.valid expected 1 actual %0b", $time, rsp_o.valid);
        end

    a_rsp_idle: assert property (@(negedge clk_i) disable iff (reset_i)
        !req_i.valid |=> !rsp_o.valid)
        else begin
            errors++;
            $display("MISMATCH at %0t: rsp_o.valid expected 0 actual %0b", $time, rsp_o.valid);
        end

    a_rsp_error: assert property (@(negedge clk_i) disable iff (reset_i)
        req_i.valid |=> (rsp_o.error == exp_rsp_q.error))
        else begin
            errors++;
            $display("MISMATCH at %0t: rsp_o.error expected %0b actual %0b",
                     $time, exp_rsp_q.error, rsp_o.error);
        end

    a_rsp_rdata: assert property (@(negedge clk_i) disable iff (reset_i)
        req_i.valid |=> (rsp_o.rdata == exp_rsp_q.rdata))
        else begin
            errors++;
            $display("MISMATCH at %0t: rsp_o.rdata expected %08h actual %08h",
                     $time, exp_rsp_q.rdata, rsp_o.rdata);
        end

    function automatic logic [ADDR_W-1:0] word_addr(input logic [3:0] region, input int word);
        return {region, 12'(word * 4)};
    endfunction

    function automatic logic access_error(input logic [ADDR_W-1:0] addr);
        case (addr[ADDR_W-1 -: REGION_W])
            REGION_ICCM:   return lock_model;
            REGION_CTRL:   return 1'b0;
            REGION_SECRET: return 1'b0;
            default:       return 1'b1;    // Unmapped nibble
        endcase
    endfunction

    // One strobe that returns 1 ns after its sampling edge
    task automatic issue(input logic write, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic exp_err,
                         input logic [DATA_W-1:0] exp_rdata);
        req_i.valid   = 1'b1;
        req_i.write   = write;
        req_i.addr    = addr;
        req_i.wdata   = wdata;
        exp_rsp.valid = 1'b1;
        exp_rsp.error = exp_err;
        exp_rsp.rdata = exp_rdata;
        @(posedge clk_i);
        #1;
        req_i.valid   = 1'b0;
        exp_rsp.valid = 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic err;
        err = access_error(addr);
        if (err) begin
            if (addr[ADDR_W-1 -: REGION_W] == REGION_ICCM) status_model[0] = 1'b1;
        end else begin
            case (addr[ADDR_W-1 -: REGION_W])
                REGION_ICCM: iccm_model[addr[5:2]] = data;
                REGION_CTRL: begin
                    case (addr[3:2])
                        2'd0: begin
                            if (data[0]) lock_model = 1'b1;
                            if (data[1]) begin
                                key_model     = '0;
                                cleared_model = 1'b1;
                            end
                        end
                        2'd1: status_model = status_model & ~data[1:0];   // Write 1 to clear
                        2'd2: en_model = data[1:0];
                        default: begin
                            gen_model       = data;
                            status_model[1] = 1'b1;
                        end
                    endcase
                end
                default: ;    // Key writes are dropped
            endcase
        end
        issue(1'b1, addr, data, err, '0);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        logic              err;
        logic [DATA_W-1:0] exp;
        err = access_error(addr);
        exp = '0;
        if (err) begin
            if (addr[ADDR_W-1 -: REGION_W] == REGION_ICCM) status_model[0] = 1'b1;
        end else begin
            case (addr[ADDR_W-1 -: REGION_W])
                REGION_ICCM: exp = iccm_model[addr[5:2]];
                REGION_CTRL: begin
                    case (addr[3:2])
                        2'd0:    exp = {31'b0, lock_model};
                        2'd1:    exp = {30'b0, status_model};
                        2'd2:    exp = {30'b0, en_model};
                        default: exp = gen_model;
                    endcase
                end
                default: exp = debug_locked_i ? key_model[addr[4:2]] : DEBUG_KEY[addr[4:2]];
            endcase
        end
        issue(1'b0, addr, '0, err, exp);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic check_outputs;
        logic [NUM_INTR-1:0] exp_intr;
        @(negedge clk_i);
        exp_intr                      = '0;
        exp_intr[INTR_CTRL_ERROR]     = status_model[0] & en_model[0];
        exp_intr[INTR_CTRL_NOTIF]     = status_model[1] & en_model[1];
        exp_intr[INTR_SECRET_CLEARED] = cleared_model;
        assert (intr_o == exp_intr) else begin
            errors++;
            $display("MISMATCH at %0t: intr_o expected %03b actual %03b", $time, exp_intr, intr_o);
        end
        assert (generic_out_o == gen_model) else begin
            errors++;
            $display("MISMATCH at %0t: generic_out_o expected %08h actual %08h",
                     $time, gen_model, generic_out_o);
        end
        @(posedge clk_i);
        #1;
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        reset_i        = 1'b1;
        req_i          = '0;
        exp_rsp        = '0;
        debug_locked_i = 1'b1;
        for (int i = 0; i < KEY_WORDS; i++) obf_key_i[i] = $random(seed);
        key_model      = obf_key_i;    // Captured right after reset
        lock_model     = 1'b0;
        status_model   = '0;
        en_model       = '0;
        gen_model      = '0;
        cleared_model  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        check_outputs();

        // Back-to-back ICCM fill and readback
        for (int i = 0; i < ICCM_WORDS; i++) write_word(word_addr(REGION_ICCM, i), $random(seed));
        for (int i = 0; i < ICCM_WORDS; i++) read_word(word_addr(REGION_ICCM, i));
        write_word(word_addr(REGION_ICCM, 5), $random(seed));
        read_word(word_addr(REGION_ICCM, 5));

        read_word(16'h3000);            // Unmapped
        write_word(16'hf004, 32'hdead_beef);

        for (int i = 0; i < KEY_WORDS; i++) read_word(word_addr(REGION_SECRET, i));
        for (int i = 0; i < 4; i++) read_word(word_addr(REGION_SECRET, i + KEY_WORDS));
        debug_locked_i = 1'b0;
        for (int i = 0; i < KEY_WORDS; i++) read_word(word_addr(REGION_SECRET, i));
        debug_locked_i = 1'b1;

        // Lock the ICCM with both interrupts enabled
        write_word(word_addr(REGION_CTRL, int'(INTR_EN)), 32'h3);
        write_word(word_addr(REGION_CTRL, int'(CTRL)), 32'h1);
        read_word(word_addr(REGION_ICCM, 2));
        write_word(word_addr(REGION_ICCM, 3), 32'h1234_5678);
        check_outputs();
        write_word(word_addr(REGION_CTRL, int'(INTR_STATUS)), 32'h1);
        read_word(word_addr(REGION_CTRL, int'(CTRL)));
        check_outputs();

        write_word(word_addr(REGION_CTRL, int'(GENERIC_OUT)), $random(seed));
        read_word(word_addr(REGION_CTRL, int'(GENERIC_OUT)));
        check_outputs();

        // Wipe lands one cycle after the strobe
        write_word(word_addr(REGION_CTRL, int'(CTRL)), 32'h2);
        idle(1);
        check_outputs();
        for (int i = 0; i < KEY_WORDS; i++) read_word(word_addr(REGION_SECRET, i));
        read_word(word_addr(REGION_CTRL, int'(CTRL)));
        idle(2);

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout after %0d cycles, the test sequence did not finish", TIMEOUT_CYCLES);
        $display("Checks stopped with %0d errors", errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/fabric_pkg.sv
verilog/bus_decoder.sv
verilog/iccm_sram.sv
verilog/soc_ctrl_regs.sv
verilog/secret_guard.sv
verilog/secure_soc_fabric.sv
dv/fabric_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module fabric_tb -f filelist.f -o fabric_sim &&
./obj_dir/fabric_sim | tee /dev/stderr | grep -F "RESULT: PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== verilog/bus_decoder.sv ====
// Expects at most one request per cycle and responders that answer exactly one cycle later.
`timescale 1ns/100ps
`default_nettype none

module bus_decoder (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  fabric_pkg::bus_req_t req_i,
    input  logic                 iccm_lock_i,
    output fabric_pkg::bus_req_t iccm_req_o,
    output fabric_pkg::bus_req_t ctrl_req_o,
    output fabric_pkg::bus_req_t secret_req_o,
    input  fabric_pkg::bus_rsp_t iccm_rsp_i,
    input  fabric_pkg::bus_rsp_t ctrl_rsp_i,
    input  fabric_pkg::bus_rsp_t secret_rsp_i,
    output logic                 iccm_blocked_o,
    output fabric_pkg::bus_rsp_t rsp_o
);
    import fabric_pkg::*;

    region_e region;
    logic    blocked;
    logic    unmapped;
    logic    err_q;      // Local error response pending

    // =========================================================================
    // Region decode
    // =========================================================================
    always_comb begin
        case (req_i.addr[ADDR_W-1 -: REGION_W])
            REGION_ICCM:   region = REGION_ICCM;
            REGION_CTRL:   region = REGION_CTRL;
            REGION_SECRET: region = REGION_SECRET;
            default:       region = REGION_NONE;
        endcase
    end

    assign blocked  = req_i.valid && (region == REGION_ICCM) && iccm_lock_i;
    assign unmapped = req_i.valid && (region == REGION_NONE);

    assign iccm_blocked_o = blocked;   // Feeds the error status bit

    // Payload goes to everyone, only the strobe is steered
    always_comb begin
        iccm_req_o         = req_i;
        ctrl_req_o         = req_i;
        secret_req_o       = req_i;
        iccm_req_o.valid   = req_i.valid && (region == REGION_ICCM) && !iccm_lock_i;
        ctrl_req_o.valid   = req_i.valid && (region == REGION_CTRL);
        secret_req_o.valid = req_i.valid && (region == REGION_SECRET);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= blocked || unmapped;
        end
    end

    // =========================================================================
    // Response merge
    // =========================================================================
    always_comb begin
        rsp_o.valid = err_q | iccm_rsp_i.valid | ctrl_rsp_i.valid | secret_rsp_i.valid;
        rsp_o.error = err_q
                    | (iccm_rsp_i.valid & iccm_rsp_i.error)
                    | (ctrl_rsp_i.valid & ctrl_rsp_i.error)
                    | (secret_rsp_i.valid & secret_rsp_i.error);
        rsp_o.rdata = '0;                         // Error responses carry zero
        if (iccm_rsp_i.valid) begin
            rsp_o.rdata = rsp_o.rdata | iccm_rsp_i.rdata;
        end
        if (ctrl_rsp_i.valid) begin
            rsp_o.rdata = rsp_o.rdata | ctrl_rsp_i.rdata;
        end
        if (secret_rsp_i.valid) begin
            rsp_o.rdata = rsp_o.rdata | secret_rsp_i.rdata;
        end
    end

    // Responders and the local error path never answer in the same cycle
    a_single_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({err_q, iccm_rsp_i.valid, ctrl_rsp_i.valid, secret_rsp_i.valid}));

    // A locked ICCM must stay silent on the following cycle
    a_lock_blocks_iccm: assert property (@(posedge clk_i) disable iff (reset_i)
        (req_i.valid && (region == REGION_ICCM) && iccm_lock_i) |=> !iccm_rsp_i.valid);

endmodule

`default_nettype wire

// ==== verilog/fabric_pkg.sv ====
// Shared bus types and address map. Accesses are whole 32-bit words and byte lanes are ignored.
`default_nettype none

package fabric_pkg;

    // =========================================================================
    // Widths
    // =========================================================================
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int KEY_WORDS  = 8;
    localparam int BYTE_OFF_W = 2;    // Word addressing
    localparam int REGION_W   = 4;    // Top address nibble picks the responder

    // Single-beat request, valid is a one-cycle strobe
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              valid;
        logic              error;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    // =========================================================================
    // Address map and control registers
    // =========================================================================
    typedef enum logic [REGION_W-1:0] {
        REGION_ICCM   = 4'h0,
        REGION_CTRL   = 4'h1,
        REGION_SECRET = 4'h2,
        REGION_NONE   = 4'hf     // Any nibble not listed above
    } region_e;

    localparam int CTRL_IDX_W = 2;

    typedef enum logic [CTRL_IDX_W-1:0] {
        CTRL        = 2'd0,
        INTR_STATUS = 2'd1,
        INTR_EN     = 2'd2,
        GENERIC_OUT = 2'd3
    } ctrl_reg_e;

    localparam int CTRL_ICCM_LOCK_BIT     = 0;    // Sticky until reset
    localparam int CTRL_CLEAR_SECRETS_BIT = 1;    // Self-clearing

    // Status and enable bits inside the control block
    localparam int NUM_CTRL_INTR    = 2;
    localparam int STATUS_ERROR_BIT = 0;
    localparam int STATUS_NOTIF_BIT = 1;

    // Positions in the outgoing interrupt vector
    localparam int NUM_INTR            = 3;
    localparam int INTR_CTRL_ERROR     = 0;
    localparam int INTR_CTRL_NOTIF     = 1;
    localparam int INTR_SECRET_CLEARED = 2;

    localparam int ICCM_WORDS = 16;
    localparam int ICCM_IDX_W = $clog2(ICCM_WORDS);
    localparam int KEY_IDX_W  = $clog2(KEY_WORDS);

    // Returned instead of the real key while debug is unlocked
    localparam logic [KEY_WORDS-1:0][DATA_W-1:0] DEBUG_KEY = {
        32'h3c1e_5a0f, 32'h9b27_d4e6, 32'h01f3_8c5d, 32'h6e4a_b219,   // Words 7..4
        32'hc75d_02a8, 32'h28bf_e361, 32'hd09a_7f34, 32'h5186_4ec2    // Words 3..0
    };

endpackage

`default_nettype wire

// ==== verilog/iccm_sram.sv ====
// Memory contents have no reset and read as undefined until written.
`timescale 1ns/100ps
`default_nettype none

module iccm_sram (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  fabric_pkg::bus_req_t req_i,
    output fabric_pkg::bus_rsp_t rsp_o
);
    import fabric_pkg::*;

    logic [DATA_W-1:0]     mem [ICCM_WORDS];
    logic [ICCM_IDX_W-1:0] idx;
    logic                  rsp_valid_q;
    logic [DATA_W-1:0]     rdata_q;

    assign idx = req_i.addr[BYTE_OFF_W +: ICCM_IDX_W];   // Upper bits alias

    always_ff @(posedge clk_i) begin
        if (req_i.valid && req_i.write) begin
            mem[idx] <= req_i.wdata;
        end
    end

    // Read data registered alongside the response strobe
    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            rdata_q <= req_i.write ? '0 : mem[idx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;
        end
    end

    always_comb begin
        rsp_o.valid = rsp_valid_q;
        rsp_o.error = 1'b0;        // Locking is handled upstream
        rsp_o.rdata = rdata_q;
    end

endmodule

`default_nettype wire

// ==== verilog/secret_guard.sv ====
// The key is sampled once after reset and a wipe holds until the next reset.
`timescale 1ns/100ps
`default_nettype none

module secret_guard (
    input  logic                                                    clk_i,
    input  logic                                                    reset_i,
    input  fabric_pkg::bus_req_t                                    req_i,
    input  logic [fabric_pkg::KEY_WORDS-1:0][fabric_pkg::DATA_W-1:0] obf_key_i,
    input  logic                                                    debug_locked_i,
    input  logic                                                    clear_secrets_i,
    output fabric_pkg::bus_rsp_t                                    rsp_o,
    output logic                                                    cleared_intr_o
);
    import fabric_pkg::*;

    logic [KEY_WORDS-1:0][DATA_W-1:0] key_q;
    logic                             captured_q;
    logic                             cleared_q;
    logic [KEY_IDX_W-1:0]             word_idx;
    logic                             rsp_valid_q;
    logic [DATA_W-1:0]                rdata_q;

    assign word_idx = req_i.addr[BYTE_OFF_W +: KEY_IDX_W];   // Wraps modulo key size

    // Wipe beats capture
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            key_q      <= '0;
            captured_q <= 1'b0;
            cleared_q  <= 1'b0;
        end else if (clear_secrets_i) begin
            key_q      <= '0;
            captured_q <= 1'b1;
            cleared_q  <= 1'b1;
        end else if (!captured_q) begin
            key_q      <= obf_key_i;
            captured_q <= 1'b1;
        end
    end

    // Debug unlocked hands out the fixed key
    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            if (req_i.write) begin
                rdata_q <= '0;
            end else if (debug_locked_i) begin
                rdata_q <= key_q[word_idx];
            end else begin
                rdata_q <= DEBUG_KEY[word_idx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;
        end
    end

    always_comb begin
        rsp_o.valid = rsp_valid_q;
        rsp_o.error = 1'b0;
        rsp_o.rdata = rdata_q;
    end

    assign cleared_intr_o = cleared_q;

endmodule

`default_nettype wire

// ==== verilog/secure_soc_fabric.sv ====
// Fabric top with one initiator port. Responses come one cycle after each request and there is no stall.
`timescale 1ns/100ps
`default_nettype none

module secure_soc_fabric (
    input  logic                                                    clk_i,
    input  logic                                                    reset_i,
    input  fabric_pkg::bus_req_t                                    req_i,
    output fabric_pkg::bus_rsp_t                                    rsp_o,
    input  logic [fabric_pkg::KEY_WORDS-1:0][fabric_pkg::DATA_W-1:0] obf_key_i,
    input  logic                                                    debug_locked_i,
    output logic [fabric_pkg::NUM_INTR-1:0]                         intr_o,
    output logic [fabric_pkg::DATA_W-1:0]                           generic_out_o
);
    import fabric_pkg::*;

    bus_req_t iccm_req;
    bus_req_t ctrl_req;
    bus_req_t secret_req;
    bus_rsp_t iccm_rsp;
    bus_rsp_t ctrl_rsp;
    bus_rsp_t secret_rsp;

    logic iccm_lock;
    logic iccm_blocked;
    logic clear_secrets;
    logic error_intr;
    logic notif_intr;
    logic cleared_intr;

    // =========================================================================
    // Decoder and responders
    // =========================================================================
    bus_decoder decoder_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_i          (req_i),
        .iccm_lock_i    (iccm_lock),
        .iccm_req_o     (iccm_req),
        .ctrl_req_o     (ctrl_req),
        .secret_req_o   (secret_req),
        .iccm_rsp_i     (iccm_rsp),
        .ctrl_rsp_i     (ctrl_rsp),
        .secret_rsp_i   (secret_rsp),
        .iccm_blocked_o (iccm_blocked),
        .rsp_o          (rsp_o)
    );

    iccm_sram iccm_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (iccm_req),
        .rsp_o   (iccm_rsp)
    );

    soc_ctrl_regs ctrl_regs_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .req_i           (ctrl_req),
        .iccm_blocked_i  (iccm_blocked),
        .rsp_o           (ctrl_rsp),
        .iccm_lock_o     (iccm_lock),
        .clear_secrets_o (clear_secrets),
        .error_intr_o    (error_intr),
        .notif_intr_o    (notif_intr),
        .generic_out_o   (generic_out_o)
    );

    secret_guard secret_guard_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .req_i           (secret_req),
        .obf_key_i       (obf_key_i),
        .debug_locked_i  (debug_locked_i),
        .clear_secrets_i (clear_secrets),
        .rsp_o           (secret_rsp),
        .cleared_intr_o  (cleared_intr)
    );

    // Interrupt vector at fixed positions
    always_comb begin
        intr_o                      = '0;
        intr_o[INTR_CTRL_ERROR]     = error_intr;
        intr_o[INTR_CTRL_NOTIF]     = notif_intr;
        intr_o[INTR_SECRET_CLEARED] = cleared_intr;
    end

endmodule

`default_nettype wire

// ==== verilog/soc_ctrl_regs.sv ====
// The ICCM lock clears only on reset, and back-to-back clear writes yield one pulse.
`timescale 1ns/100ps
`default_nettype none

module soc_ctrl_regs (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  fabric_pkg::bus_req_t          req_i,
    input  logic                          iccm_blocked_i,
    output fabric_pkg::bus_rsp_t          rsp_o,
    output logic                          iccm_lock_o,
    output logic                          clear_secrets_o,
    output logic                          error_intr_o,
    output logic                          notif_intr_o,
    output logic [fabric_pkg::DATA_W-1:0] generic_out_o
);
    import fabric_pkg::*;

    ctrl_reg_e              reg_sel;
    logic                   wr_en;
    logic                   clear_hit;
    logic                   lock_q;
    logic                   clear_q;
    logic [NUM_CTRL_INTR-1:0] status_q;
    logic [NUM_CTRL_INTR-1:0] status_nxt;
    logic [NUM_CTRL_INTR-1:0] enable_q;
    logic [DATA_W-1:0]      gen_out_q;
    logic                   rsp_valid_q;
    logic [DATA_W-1:0]      rdata_q;
    logic [DATA_W-1:0]      rdata_nxt;

    assign reg_sel   = ctrl_reg_e'(req_i.addr[BYTE_OFF_W +: CTRL_IDX_W]);
    assign wr_en     = req_i.valid && req_i.write;
    assign clear_hit = wr_en && (reg_sel == CTRL) && req_i.wdata[CTRL_CLEAR_SECRETS_BIT];

    // =========================================================================
    // Interrupt status, set wins over write-1-to-clear
    // =========================================================================
    always_comb begin
        status_nxt = status_q;
        if (wr_en && (reg_sel == INTR_STATUS)) begin
            status_nxt = status_q & ~req_i.wdata[NUM_CTRL_INTR-1:0];
        end
        if (iccm_blocked_i) begin
            status_nxt[STATUS_ERROR_BIT] = 1'b1;
        end
        if (wr_en && (reg_sel == GENERIC_OUT)) begin
            status_nxt[STATUS_NOTIF_BIT] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lock_q    <= 1'b0;
            clear_q   <= 1'b0;
            status_q  <= '0;
            enable_q  <= '0;
            gen_out_q <= '0;
        end else begin
            if (wr_en && (reg_sel == CTRL) && req_i.wdata[CTRL_ICCM_LOCK_BIT]) begin
                lock_q <= 1'b1;     // Sticky
            end
            clear_q  <= clear_hit && !clear_q;
            status_q <= status_nxt;
            if (wr_en && (reg_sel == INTR_EN)) begin
                enable_q <= req_i.wdata[NUM_CTRL_INTR-1:0];
            end
            if (wr_en && (reg_sel == GENERIC_OUT)) begin
                gen_out_q <= req_i.wdata;
            end
        end
    end

    // =========================================================================
    // Readback
    // =========================================================================
    always_comb begin
        rdata_nxt = '0;
        if (!req_i.write) begin
            case (reg_sel)
                CTRL:        rdata_nxt[CTRL_ICCM_LOCK_BIT] = lock_q;  // Clear bit reads 0
                INTR_STATUS: rdata_nxt[NUM_CTRL_INTR-1:0] = status_q;
                INTR_EN:     rdata_nxt[NUM_CTRL_INTR-1:0] = enable_q;
                GENERIC_OUT: rdata_nxt = gen_out_q;
                default:     rdata_nxt = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            rdata_q <= rdata_nxt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;
        end
    end

    always_comb begin
        rsp_o.valid = rsp_valid_q;
        rsp_o.error = 1'b0;
        rsp_o.rdata = rdata_q;
    end

    assign iccm_lock_o     = lock_q;
    assign clear_secrets_o = clear_q;
    assign error_intr_o    = status_q[STATUS_ERROR_BIT] & enable_q[STATUS_ERROR_BIT];
    assign notif_intr_o    = status_q[STATUS_NOTIF_BIT] & enable_q[STATUS_NOTIF_BIT];
    assign generic_out_o   = gen_out_q;

    // Secret wipe is a strobe for the key holder
    a_clear_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        clear_secrets_o |=> !clear_secrets_o);

endmodule

`default_nettype wire
